//--- arcade_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Arcade shell shared types
// Structs, enums and width defaults used across the glue shell
////////////////////////////////////////////////////////////////////////////

package arcade_pkg;

	localparam int rom_addr_w = 12; // 4 KiB image
	localparam int rom_data_w = 8;

	typedef struct packed {
		logic [rom_addr_w-1:0] addr;
		logic [7:0]            data;
		logic                  last; // Final byte of the image
	} dl_byte_t;

	typedef struct packed {
		logic [7:0] code;
		logic       pressed;
	} key_event_t;

	// Right sits in bit 0, as on the host joystick word
	typedef struct packed {
		logic fire3;
		logic fire2;
		logic fire1;
		logic up;
		logic down;
		logic left;
		logic right;
	} joy_t;

	typedef struct packed {
		logic up;
		logic down;
		logic thrust;
		logic fire1;
		logic fire2;
		logic fire3;
		logic coin;
		logic start1;
		logic start2;
		logic advance;
		logic auto_up;
		logic service;
	} controls_t;

	typedef struct packed {
		logic [2:0] r;
		logic [2:0] g;
		logic [1:0] b;
		logic       hs;
		logic       vs;
		logic       blank_n;
	} pixel_in_t;

	typedef struct packed {
		logic [5:0] r;
		logic [5:0] g;
		logic [5:0] b;
		logic       hs;
		logic       vs;
	} pixel_out_t;

	typedef enum logic [1:0] {
		ld_idle,
		ld_loading,
		ld_loaded
	} loader_state_t;

	typedef enum logic [1:0] {
		scan_off,
		scan_pct25,
		scan_pct50,
		scan_pct75
	} scan_level_t;

	typedef enum logic [7:0] {
		key_up    = 8'h75,
		key_down  = 8'h72,
		key_left  = 8'h6B,
		key_right = 8'h74,
		key_esc   = 8'h76,
		key_f1    = 8'h05,
		key_f2    = 8'h06,
		key_ctrl  = 8'h14,
		key_alt   = 8'h11,
		key_space = 8'h29,
		key_a     = 8'h1C,
		key_u     = 8'h3C,
		key_h     = 8'h33
	} key_code_t;

endpackage

//--- rom_loader.sv
////////////////////////////////////////////////////////////////////////////
// ROM loader
// Takes the download byte stream, writes it to the ROM store and holds
// the game core in reset until a complete image is present
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module rom_loader #(
	parameter int addr_w = arcade_pkg::rom_addr_w
) (
	input  logic                 clk_sys,
	input  logic                 rst_n,
	input  logic                 dl_valid,
	input  arcade_pkg::dl_byte_t dl,
	input  logic                 user_reset,
	output logic                 dl_ready,
	output logic                 wr_en,
	output logic [addr_w-1:0]    wr_addr,
	output logic [7:0]           wr_data,
	output logic                 rom_busy,
	output logic                 core_reset
);

	arcade_pkg::loader_state_t state;
	arcade_pkg::loader_state_t state_nxt;
	logic                      accept;

	// On-chip store takes one byte every cycle in every state
	assign dl_ready = 1'b1;
	assign accept   = dl_valid & dl_ready;

	// Accepted byte goes straight to the write port
	assign wr_en   = accept;
	assign wr_addr = dl.addr;
	assign wr_data = dl.data;

	assign rom_busy = (state == arcade_pkg::ld_loading);

	always_comb begin
		state_nxt = state;
		case (state)
			arcade_pkg::ld_idle,
			arcade_pkg::ld_loading,
			arcade_pkg::ld_loaded: begin
				if (accept) begin
					if (dl.last)
						state_nxt = arcade_pkg::ld_loaded;
					else
						state_nxt = arcade_pkg::ld_loading; // Also restarts a reload
				end
			end
			default: state_nxt = arcade_pkg::ld_idle;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			state      <= arcade_pkg::ld_idle;
			core_reset <= 1'b1;
		end else begin
			state <= state_nxt;
			// Not loaded covers the loading state as well
			core_reset <= user_reset | (state_nxt != arcade_pkg::ld_loaded);
		end
	end

endmodule

//--- rom_store.sv
////////////////////////////////////////////////////////////////////////////
// ROM store
// Synchronous array, download write port and game read port
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module rom_store #(
	parameter int addr_w = arcade_pkg::rom_addr_w,
	parameter int data_w = arcade_pkg::rom_data_w
) (
	input  logic              clk_sys,
	input  logic              rst_n,
	input  logic              wr_en,
	input  logic [addr_w-1:0] wr_addr,
	input  logic [data_w-1:0] wr_data,
	input  logic              rd_en,
	input  logic [addr_w-1:0] rd_addr,
	input  logic              rom_busy,
	output logic [data_w-1:0] rd_data,
	output logic              rd_valid
);

	localparam int depth = 1 << addr_w;

	logic [data_w-1:0] mem [0:depth-1];
	logic              rd_ok;

	// Game fetches during a download are dropped
	assign rd_ok = rd_en & ~rom_busy;

	always_ff @(posedge clk_sys) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
		if (rd_ok)
			rd_data <= mem[rd_addr]; // Old data on a same-address write
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n)
			rd_valid <= 1'b0;
		else
			rd_valid <= rd_ok;
	end

endmodule

//--- key_mapper.sv
////////////////////////////////////////////////////////////////////////////
// Key mapper
// Latches keyboard buttons and merges them with both joysticks
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module key_mapper (
	input  logic                   clk_sys,
	input  logic                   rst_n,
	input  logic                   key_valid,
	input  arcade_pkg::key_event_t key,
	input  arcade_pkg::joy_t       joy0,
	input  arcade_pkg::joy_t       joy1,
	output arcade_pkg::controls_t  controls
);

	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire1;
		logic fire2;
		logic fire3;
		logic coin;
		logic start1;
		logic start2;
		logic advance;
		logic auto_up;
		logic service;
	} btn_t;

	btn_t                  btn;
	btn_t                  btn_nxt;
	arcade_pkg::controls_t ctl_nxt;

	always_comb begin
		btn_nxt = btn;
		if (key_valid) begin
			case (arcade_pkg::key_code_t'(key.code))
				arcade_pkg::key_up:    btn_nxt.up      = key.pressed;
				arcade_pkg::key_down:  btn_nxt.down    = key.pressed;
				arcade_pkg::key_left:  btn_nxt.left    = key.pressed;
				arcade_pkg::key_right: btn_nxt.right   = key.pressed;
				arcade_pkg::key_esc:   btn_nxt.coin    = key.pressed;
				arcade_pkg::key_f1:    btn_nxt.start1  = key.pressed;
				arcade_pkg::key_f2:    btn_nxt.start2  = key.pressed;
				arcade_pkg::key_ctrl:  btn_nxt.fire3   = key.pressed;
				arcade_pkg::key_alt:   btn_nxt.fire2   = key.pressed;
				arcade_pkg::key_space: btn_nxt.fire1   = key.pressed;
				arcade_pkg::key_a:     btn_nxt.advance = key.pressed;
				arcade_pkg::key_u:     btn_nxt.auto_up = key.pressed;
				arcade_pkg::key_h:     btn_nxt.service = key.pressed;
				default: ; // Unmapped scan code
			endcase
		end
	end

	always_comb begin
		ctl_nxt.up      = btn_nxt.up | joy0.up | joy1.up;
		ctl_nxt.down    = btn_nxt.down | joy0.down | joy1.down;
		// Game has a single horizontal direction
		ctl_nxt.thrust  = btn_nxt.left | btn_nxt.right | joy0.left | joy0.right |
		                  joy1.left | joy1.right;
		ctl_nxt.fire1   = btn_nxt.fire1 | joy0.fire1 | joy1.fire1;
		ctl_nxt.fire2   = btn_nxt.fire2 | joy0.fire2 | joy1.fire2;
		ctl_nxt.fire3   = btn_nxt.fire3 | joy0.fire3 | joy1.fire3;
		ctl_nxt.coin    = btn_nxt.coin;
		ctl_nxt.start1  = btn_nxt.start1;
		ctl_nxt.start2  = btn_nxt.start2;
		ctl_nxt.advance = btn_nxt.advance;
		ctl_nxt.auto_up = btn_nxt.auto_up;
		ctl_nxt.service = btn_nxt.service;
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			btn      <= '0;
			controls <= '0;
		end else begin
			btn      <= btn_nxt;
			controls <= ctl_nxt;
		end
	end

endmodule

//--- video_out.sv
////////////////////////////////////////////////////////////////////////////
// Video output stage
// Blanks and expands 3/3/2 pixels to 6 bits, dims odd lines
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module video_out (
	input  logic                    clk_sys,
	input  logic                    rst_n,
	input  arcade_pkg::pixel_in_t   pix_in,
	input  arcade_pkg::scan_level_t scan_level,
	input  logic                    line_odd,
	output arcade_pkg::pixel_out_t  pix_out
);

	arcade_pkg::pixel_out_t pix_nxt;
	logic [5:0]             r_exp;
	logic [5:0]             g_exp;
	logic [5:0]             b_exp;

	function automatic logic [5:0] dim(
		input logic [5:0]              v,
		input arcade_pkg::scan_level_t lvl
	);
		logic [5:0] res;
		case (lvl)
			arcade_pkg::scan_pct25: res = v - (v >> 2);
			arcade_pkg::scan_pct50: res = v >> 1;
			arcade_pkg::scan_pct75: res = v >> 2;
			default:                res = v;
		endcase
		return res;
	endfunction

	// Bit repetition keeps full white at full scale
	always_comb begin
		r_exp = '0;
		g_exp = '0;
		b_exp = '0;
		if (pix_in.blank_n) begin
			r_exp = {pix_in.r, pix_in.r};
			g_exp = {pix_in.g, pix_in.g};
			b_exp = {3{pix_in.b}};
		end
	end

	always_comb begin
		pix_nxt.r  = line_odd ? dim(r_exp, scan_level) : r_exp;
		pix_nxt.g  = line_odd ? dim(g_exp, scan_level) : g_exp;
		pix_nxt.b  = line_odd ? dim(b_exp, scan_level) : b_exp;
		pix_nxt.hs = pix_in.hs;
		pix_nxt.vs = pix_in.vs; // Syncs share the colour delay
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n)
			pix_out <= '0;
		else
			pix_out <= pix_nxt;
	end

endmodule

//--- arcade_shell.sv
////////////////////////////////////////////////////////////////////////////
// Arcade glue shell
// ROM download, core reset, cabinet controls and video output
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module arcade_shell #(
	parameter int rom_addr_w = arcade_pkg::rom_addr_w,
	parameter int rom_data_w = arcade_pkg::rom_data_w
) (
	input  logic                    clk_sys,
	input  logic                    rst_n,
	input  logic                    dl_valid,
	input  arcade_pkg::dl_byte_t    dl,
	output logic                    dl_ready,
	input  logic                    user_reset,
	input  logic                    rd_en,
	input  logic [rom_addr_w-1:0]   rd_addr,
	output logic [rom_data_w-1:0]   rd_data,
	output logic                    rd_valid,
	output logic                    core_reset,
	input  logic                    key_valid,
	input  arcade_pkg::key_event_t  key,
	input  arcade_pkg::joy_t        joy0,
	input  arcade_pkg::joy_t        joy1,
	output arcade_pkg::controls_t   controls,
	input  arcade_pkg::pixel_in_t   pix_in,
	input  arcade_pkg::scan_level_t scan_level,
	input  logic                    line_odd,
	output arcade_pkg::pixel_out_t  pix_out
);

	logic                  wr_en;
	logic [rom_addr_w-1:0] wr_addr;
	logic [rom_data_w-1:0] wr_data;
	logic                  rom_busy;

	rom_loader #(.addr_w(rom_addr_w)) u_loader (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.dl_valid  (dl_valid),
		.dl        (dl),
		.user_reset(user_reset),
		.dl_ready  (dl_ready),
		.wr_en     (wr_en),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data),
		.rom_busy  (rom_busy),
		.core_reset(core_reset)
	);

	rom_store #(.addr_w(rom_addr_w), .data_w(rom_data_w)) u_store (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.rd_en   (rd_en),
		.rd_addr (rd_addr),
		.rom_busy(rom_busy),
		.rd_data (rd_data),
		.rd_valid(rd_valid)
	);

	key_mapper u_keys (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.key_valid(key_valid),
		.key      (key),
		.joy0     (joy0),
		.joy1     (joy1),
		.controls (controls)
	);

	video_out u_video (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.pix_in    (pix_in),
		.scan_level(scan_level),
		.line_odd  (line_odd),
		.pix_out   (pix_out)
	);

endmodule

//--- arcade_shell_sva.sv
////////////////////////////////////////////////////////////////////////////
// Arcade shell assertions
// Download handshake, dropped reads and core reset during a download
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module arcade_shell_sva (
	input logic                 clk_sys,
	input logic                 rst_n,
	input logic                 dl_valid,
	input arcade_pkg::dl_byte_t dl,
	input logic                 dl_ready,
	input logic                 rd_en,
	input logic                 rd_valid,
	input logic                 rom_busy,
	input logic                 core_reset
);

	dl_hold: assert property (@(posedge clk_sys) disable iff (!rst_n)
		dl_valid && !dl_ready |=> $stable(dl))
		else $error("Download byte changed while stalled");

	busy_read_dropped: assert property (@(posedge clk_sys) disable iff (!rst_n)
		rd_en && rom_busy |=> !rd_valid)
		else $error("Read during download returned data");

	busy_holds_reset: assert property (@(posedge clk_sys) disable iff (!rst_n)
		rom_busy |-> core_reset)
		else $error("Core left reset during download");

endmodule

bind arcade_shell arcade_shell_sva u_sva (
	.clk_sys   (clk_sys),
	.rst_n     (rst_n),
	.dl_valid  (dl_valid),
	.dl        (dl),
	.dl_ready  (dl_ready),
	.rd_en     (rd_en),
	.rd_valid  (rd_valid),
	.rom_busy  (rom_busy),
	.core_reset(core_reset)
);

//--- arcade_shell_tb.sv
////////////////////////////////////////////////////////////////////////////
// Arcade shell testbench
// Replays the command file against the shell and checks each response
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module arcade_shell_tb;

	localparam int addr_w   = arcade_pkg::rom_addr_w;
	localparam int data_w   = arcade_pkg::rom_data_w;
	localparam int wait_max = 20;

	logic                    clk_sys;
	logic                    rst_n;
	logic                    dl_valid;
	arcade_pkg::dl_byte_t    dl;
	logic                    dl_ready;
	logic                    user_reset;
	logic                    rd_en;
	logic [addr_w-1:0]       rd_addr;
	logic [data_w-1:0]       rd_data;
	logic                    rd_valid;
	logic                    core_reset;
	logic                    key_valid;
	arcade_pkg::key_event_t  key;
	arcade_pkg::joy_t        joy0;
	arcade_pkg::joy_t        joy1;
	arcade_pkg::controls_t   controls;
	arcade_pkg::pixel_in_t   pix_in;
	arcade_pkg::scan_level_t scan_level;
	logic                    line_odd;
	arcade_pkg::pixel_out_t  pix_out;

	integer errors;
	integer checks;
	integer seed;
	logic   timed_out;

	arcade_shell #(.rom_addr_w(addr_w), .rom_data_w(data_w)) uut (.*);

	always #20 clk_sys = ~clk_sys;

	task automatic next_cycle;
		@(posedge clk_sys);
		#5; // Drive point after the edge
	endtask

	task automatic report_mismatch(input string what, input logic [31:0] got,
	                               input logic [31:0] exp);
		errors++;
		$display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
	endtask

	task automatic flag_timeout(input string what);
		errors++;
		timed_out = 1'b1;
		$display("Timed out waiting for %s at %0t", what, $time);
	endtask

	task automatic send_byte(input logic [31:0] addr, input logic [31:0] data,
	                         input logic [31:0] last);
		integer gap;
		integer tries;
		logic   exp;
		gap = $unsigned($random(seed)) % 3;
		repeat (gap) next_cycle(); // Host pauses the stream
		dl_valid = 1'b1;
		dl.addr  = addr[addr_w-1:0];
		dl.data  = data[7:0];
		dl.last  = last[0];
		tries    = 0;
		while (!dl_ready && tries < wait_max) begin
			next_cycle();
			tries++;
		end
		if (!dl_ready) begin
			dl_valid = 1'b0;
			flag_timeout("dl_ready");
		end else begin
			next_cycle();
			dl_valid = 1'b0;
			// Image is complete only after a last byte
			exp = user_reset | ~last[0];
			checks++;
			if (core_reset !== exp)
				report_mismatch("core_reset", 32'(core_reset), 32'(exp));
		end
	endtask

	task automatic read_byte(input logic [31:0] addr, input logic [31:0] exp);
		integer tries;
		rd_en   = 1'b1;
		rd_addr = addr[addr_w-1:0];
		next_cycle();
		rd_en = 1'b0;
		tries = 0;
		while (!rd_valid && tries < wait_max) begin
			next_cycle();
			tries++;
		end
		if (!rd_valid) begin
			flag_timeout("rd_valid");
		end else begin
			checks++;
			if (tries != 0)
				report_mismatch("read latency", tries + 1, 1);
			if (rd_data !== exp[data_w-1:0])
				report_mismatch("rd_data", 32'(rd_data), exp);
		end
	endtask

	initial begin
		integer         fd;
		integer         r;
		string          op;
		logic [31:0]    f1, f2, f3, f4;
		logic [959:0]   rest;
		errors     = 0;
		checks     = 0;
		seed       = 32'h574d;
		timed_out  = 1'b0;
		clk_sys    = 1'b0;
		rst_n      = 1'b0;
		dl_valid   = 1'b0;
		dl         = '0;
		user_reset = 1'b0;
		rd_en      = 1'b0;
		rd_addr    = '0;
		key_valid  = 1'b0;
		key        = '0;
		joy0       = '0;
		joy1       = '0;
		pix_in     = '0;
		scan_level = arcade_pkg::scan_off;
		line_odd   = 1'b0;
		repeat (5) @(posedge clk_sys);
		#5;
		rst_n = 1'b1;
		next_cycle(); // Idle, nothing downloaded yet
		checks++;
		if (core_reset !== 1'b1)
			report_mismatch("core_reset after reset", 32'(core_reset), 1);
		if (dl_ready !== 1'b1)
			report_mismatch("dl_ready after reset", 32'(dl_ready), 1);
		if (rd_valid !== 1'b0)
			report_mismatch("rd_valid after reset", 32'(rd_valid), 0);
		if (controls !== '0)
			report_mismatch("controls after reset", 32'(controls), 0);
		if (pix_out !== '0)
			report_mismatch("pix_out after reset", 32'(pix_out), 0);
		fd = $fopen("arcade_testdata.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("Could not open the test data file arcade_testdata.txt");
		end else begin
			while (!$feof(fd) && !timed_out) begin
				r = $fscanf(fd, " %s", op);
				if (r == 1) begin
					if (op == "#") begin
						r = $fgets(rest, fd);
					end else if (op == "load") begin
						r = $fscanf(fd, " %h %h %h", f1, f2, f3);
						send_byte(f1, f2, f3);
					end else if (op == "read") begin
						r = $fscanf(fd, " %h %h", f1, f2);
						read_byte(f1, f2);
					end else if (op == "key") begin
						r = $fscanf(fd, " %h %h %h", f1, f2, f3);
						key_valid   = 1'b1;
						key.code    = f1[7:0];
						key.pressed = f2[0];
						next_cycle();
						key_valid = 1'b0;
						checks++;
						if (controls !== f3[11:0])
							report_mismatch("controls", 32'(controls), f3);
					end else if (op == "joy") begin
						r = $fscanf(fd, " %h %h %h", f1, f2, f3);
						joy0 = f1[6:0];
						joy1 = f2[6:0];
						next_cycle();
						checks++;
						if (controls !== f3[11:0])
							report_mismatch("controls", 32'(controls), f3);
					end else if (op == "pix") begin
						r = $fscanf(fd, " %h %h %h %h", f1, f2, f3, f4);
						pix_in     = f1[10:0];
						scan_level = arcade_pkg::scan_level_t'(f2[1:0]);
						line_odd   = f3[0];
						next_cycle();
						checks++;
						if (pix_out !== f4[19:0])
							report_mismatch("pix_out", 32'(pix_out), f4);
					end else if (op == "ureset") begin
						r = $fscanf(fd, " %h %h", f1, f2);
						user_reset = f1[0];
						next_cycle();
						checks++;
						if (core_reset !== f2[0])
							report_mismatch("core_reset", 32'(core_reset), f2);
					end else begin
						errors++;
						$display("Unknown command %s in the test data", op);
					end
				end
			end
			$fclose(fd);
		end
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

//--- arcade_testdata.txt
# load addr data last | read addr data | key code pressed controls | joy joy0 joy1 controls
# pix pixel level odd pix_out | ureset value core_reset   (all fields hex)
load 010 a5 0
load 011 3c 0
load 012 7e 0
load 013 c3 1
read 010 a5
read 011 3c
read 012 7e
read 013 c3
load 011 99 0
load 012 42 1
read 011 99
read 012 42
read 010 a5
key 75 1 800
key 6b 1 a00
key 74 1 a00
key 6b 0 a00
key 74 0 800
key 29 1 900
key 76 1 920
key 4a 1 920
joy 05 20 fa0
joy 00 00 920
pix 575 0 0 b5baa
pix 575 3 0 b5baa
pix 575 0 1 b5baa
pix 575 1 1 89582
pix 575 2 1 58d56
pix 575 3 1 2c62a
pix 576 0 0 00003
pix 7ff 0 0 fffff
ureset 1 1
ureset 0 0

//--- filelist.f
arcade_pkg.sv
rom_loader.sv
rom_store.sv
key_mapper.sv
video_out.sv
arcade_shell.sv
arcade_shell_sva.sv
arcade_shell_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the arcade shell testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module arcade_shell_tb -o arcade_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/arcade_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "Finished with no errors"; then
	exit 0
fi
exit 1
